//--- sim.f
+incdir+.
rdma_cmd_pkg.sv
rdma_pkt_pkg.sv
meta_fifo.sv
rdma_tx_engine.sv
rdma_ack_rx.sv
roce_stack.sv
roce_stack_assert.sv
tb_roce_stack.sv

//--- Makefile
# Verilator build and run for the RoCE stack testbench

TOP := tb_roce_stack

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -o vsim

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/vsim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- tb_roce_stack.sv
// RoCE stack testbench
// Drives work requests and acknowledgements into the top level,
// models psn tables and drop counts, and checks every output
`timescale 1ns/10ps
`include "rdma_config.svh"

module tb_roce_stack
  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;
();

  localparam int N_CMDS = 30;
  localparam int CLK_NS = 20;

  logic                      nclk;
  logic                      nresetn;
  logic [31:0]               local_ip_address;
  logic                      sq_req_valid;
  logic                      sq_req_ready;
  rdma_sq_req_t              sq_req;
  logic                      tx_hdr_valid;
  logic                      tx_hdr_ready = 1'b1;
  rdma_tx_hdr_t              tx_hdr;
  logic                      mem_rd_req_valid;
  logic                      mem_rd_req_ready = 1'b1;
  rdma_mem_req_t             mem_rd_req;
  logic                      rx_ack_valid;
  logic                      rx_ack_ready;
  rdma_ack_pkt_t             rx_ack;
  logic                      ack_valid;
  rdma_ack_t                 ack;
  logic                      crc_drop_count_valid;
  logic [31:0]               crc_drop_count;
  logic                      psn_drop_count_valid;
  logic [31:0]               psn_drop_count;

  integer                    seed = 42069;
  logic                      random_bp;
  int                        errors;
  rdma_tx_hdr_t              hdr_q [$];
  rdma_mem_req_t             mem_q [$];
  rdma_ack_t                 ack_q [$];
  logic [`RDMA_PSN_BITS-1:0] model_tx_psn [`RDMA_N_QP];
  logic [`RDMA_PSN_BITS-1:0] model_rx_psn [`RDMA_N_QP];
  logic [`RDMA_PSN_BITS-1:0] stim_psn [`RDMA_N_QP];
  logic [31:0]               exp_crc;
  logic [31:0]               exp_psnd;
  logic [31:0]               crc_seen;
  logic [31:0]               psn_seen;
  rdma_tx_hdr_t              new_hdr;
  rdma_mem_req_t             new_mem;
  rdma_ack_t                 new_ack;
  rdma_tx_hdr_t              exp_hdr;
  rdma_mem_req_t             exp_mem;
  rdma_ack_t                 exp_ack;

  roce_stack DUT (.*);

  bind roce_stack roce_stack_assert checks (.*);

  initial nclk = 1'b0;
  always #(CLK_NS / 2) nclk = ~nclk;

  // Random stalls on the header and memory outputs
  always @(posedge nclk) begin
    if (random_bp) begin
      tx_hdr_ready     <= (($random(seed) % 3) != 0);
      mem_rd_req_ready <= (($random(seed) % 3) != 0);
    end else begin
      tx_hdr_ready     <= 1'b1;
      mem_rd_req_ready <= 1'b1;
    end
  end

  // Reference model fed at each input transfer
  always @(posedge nclk) begin
    if (nresetn && sq_req_valid && sq_req_ready) begin
      new_hdr.op     = sq_req.op;
      new_hdr.qpn    = sq_req.qpn;
      new_hdr.psn    = model_tx_psn[sq_req.qpn];
      new_hdr.src_ip = local_ip_address;
      new_hdr.pid    = sq_req.pid;
      new_hdr.len    = sq_req.len;
      hdr_q.push_back(new_hdr);
      model_tx_psn[sq_req.qpn] = model_tx_psn[sq_req.qpn] + 1;
      if (sq_req.op == RDMA_WRITE) begin
        new_mem.vaddr = sq_req.vaddr;
        new_mem.len   = sq_req.len;
        new_mem.pid   = sq_req.pid;
        new_mem.qpn   = sq_req.qpn;
        mem_q.push_back(new_mem);
      end
    end
    if (nresetn && rx_ack_valid && rx_ack_ready) begin
      if (!rx_ack.crc_ok) exp_crc = exp_crc + 1;
      else if (rx_ack.psn != model_rx_psn[rx_ack.qpn]) exp_psnd = exp_psnd + 1;
      else begin
        new_ack.qpn      = rx_ack.qpn;
        new_ack.pid      = rx_ack.pid;
        new_ack.is_nak   = rx_ack.is_nak;
        new_ack.syndrome = rx_ack.syndrome;
        new_ack.msn      = rx_ack.psn;
        ack_q.push_back(new_ack);
        model_rx_psn[rx_ack.qpn] = model_rx_psn[rx_ack.qpn] + 1;
      end
    end
  end

  // Output checks
  always @(posedge nclk) begin
    if (nresetn && tx_hdr_valid && tx_hdr_ready) begin
      assert (hdr_q.size() != 0) else begin
        $display("tx_hdr transfer with no request pending");
        errors++;
      end
      if (hdr_q.size() != 0) begin
        exp_hdr = hdr_q.pop_front();
        assert (tx_hdr == exp_hdr) else begin
          $display("[FAIL] tx_hdr expected %h got %h", exp_hdr, tx_hdr);
          errors++;
        end
      end
    end
    if (nresetn && mem_rd_req_valid && mem_rd_req_ready) begin
      assert (mem_q.size() != 0) else begin
        $display("mem_rd_req issued with no WRITE pending");
        errors++;
      end
      if (mem_q.size() != 0) begin
        exp_mem = mem_q.pop_front();
        assert (mem_rd_req == exp_mem) else begin
          $display("[FAIL] mem_rd_req expected %h got %h", exp_mem, mem_rd_req);
          errors++;
        end
      end
    end
    if (nresetn && ack_valid) begin
      assert (ack_q.size() != 0) else begin
        $display("ack notice with no good acknowledgement pending");
        errors++;
      end
      if (ack_q.size() != 0) begin
        exp_ack = ack_q.pop_front();
        assert (ack == exp_ack) else begin
          $display("[FAIL] ack expected %h got %h", exp_ack, ack);
          errors++;
        end
      end
    end
    if (nresetn && crc_drop_count_valid) begin
      crc_seen = crc_seen + 1;
      assert (crc_drop_count == crc_seen) else begin
        $display("[FAIL] crc_drop_count expected %h got %h", crc_seen, crc_drop_count);
        errors++;
      end
    end
    if (nresetn && psn_drop_count_valid) begin
      psn_seen = psn_seen + 1;
      assert (psn_drop_count == psn_seen) else begin
        $display("[FAIL] psn_drop_count expected %h got %h", psn_seen, psn_drop_count);
        errors++;
      end
    end
  end

  function automatic rdma_sq_req_t make_req(input rdma_op_e op, input logic [1:0] qpn,
                                            input logic [5:0] pid, input logic [47:0] vaddr,
                                            input logic [27:0] len);
    rdma_sq_req_t r;
    r.op    = op;
    r.qpn   = qpn;
    r.pid   = pid;
    r.vaddr = vaddr;
    r.len   = len;
    return r;
  endfunction

  task automatic offer_req(input rdma_sq_req_t r);
    @(posedge nclk);
    sq_req_valid <= 1'b1;
    sq_req       <= r;
  endtask

  task automatic wait_accept();
    do @(posedge nclk); while (!sq_req_ready);
    sq_req_valid <= 1'b0;
  endtask

  task automatic send_req(input rdma_sq_req_t r);
    offer_req(r);
    wait_accept();
  endtask

  // No transfer allowed while credit is used up
  task automatic expect_blocked(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(posedge nclk);
      assert (!sq_req_ready) else begin
        $display("sq_req accepted beyond the outstanding limit");
        errors++;
      end
    end
  endtask

  task automatic send_ack(input logic [1:0] qpn, input logic [23:0] psn, input logic [5:0] pid,
                          input logic is_nak, input logic crc_ok);
    @(posedge nclk);
    rx_ack_valid    <= 1'b1;
    rx_ack.qpn      <= qpn;
    rx_ack.psn      <= psn;
    rx_ack.pid      <= pid;
    rx_ack.is_nak   <= is_nak;
    rx_ack.syndrome <= is_nak ? 8'h61 : 8'h00;
    rx_ack.crc_ok   <= crc_ok;
    do @(posedge nclk); while (!rx_ack_ready);
    rx_ack_valid <= 1'b0;
  endtask

  task automatic send_good_ack(input logic [1:0] qpn, input logic [5:0] pid,
                               input logic is_nak);
    send_ack(qpn, stim_psn[qpn], pid, is_nak, 1'b1);
    stim_psn[qpn] = stim_psn[qpn] + 1;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (n < 300 && !(hdr_q.size() == 0 && mem_q.size() == 0 && ack_q.size() == 0 &&
                        crc_seen == exp_crc && psn_seen == exp_psnd)) begin
      @(posedge nclk);
      n++;
    end
    if (n == 300) begin
      $display("outputs did not drain in time");
      errors++;
    end
    repeat (4) @(posedge nclk);
  endtask

  initial begin
    nresetn          = 1'b0;
    local_ip_address = 32'hc0a8_0a05;
    sq_req_valid     = 1'b0;
    sq_req           = '0;
    rx_ack_valid     = 1'b0;
    rx_ack           = '0;
    random_bp        = 1'b0;
    errors           = 0;
    exp_crc          = '0;
    exp_psnd         = '0;
    crc_seen         = '0;
    psn_seen         = '0;
    for (int q = 0; q < `RDMA_N_QP; q++) begin
      model_tx_psn[q] = '0;
      model_rx_psn[q] = '0;
      stim_psn[q]     = '0;
    end
    repeat (5) @(posedge nclk);
    nresetn <= 1'b1;
    repeat (2) @(posedge nclk);

    // Four WRITE and READ requests use up all credit
    send_req(make_req(RDMA_WRITE, 2'd0, 6'h11, 48'h0000_1000_0040, 28'h100));
    send_req(make_req(RDMA_READ, 2'd0, 6'h12, 48'h0000_2000_0000, 28'h40));
    send_req(make_req(RDMA_WRITE, 2'd1, 6'h13, 48'h0abc_0000_1000, 28'h800));
    send_req(make_req(RDMA_READ, 2'd2, 6'h14, 48'h0000_0000_3000, 28'h20));
    offer_req(make_req(RDMA_WRITE, 2'd3, 6'h15, 48'h0001_0000_0000, 28'h10));
    expect_blocked(10);
    // One ack frees exactly one slot
    send_good_ack(2'd0, 6'h11, 1'b0);
    wait_accept();
    offer_req(make_req(RDMA_READ, 2'd3, 6'h16, 48'h0000_0000_8000, 28'h4));
    expect_blocked(10);
    send_good_ack(2'd0, 6'h12, 1'b1);
    wait_accept();

    // Bad CRC then an out of sequence psn
    send_ack(2'd1, 24'd0, 6'h13, 1'b0, 1'b0);
    send_ack(2'd1, 24'd5, 6'h13, 1'b0, 1'b1);
    wait_idle();
    send_good_ack(2'd1, 6'h13, 1'b0);
    send_good_ack(2'd2, 6'h14, 1'b0);
    send_good_ack(2'd3, 6'h15, 1'b0);
    send_good_ack(2'd3, 6'h16, 1'b1);
    wait_idle();

    // Random stalls on both outputs
    random_bp <= 1'b1;
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 4; i++) begin
        send_req(make_req((i % 2 == 1) ? RDMA_READ : RDMA_WRITE, 2'(i), 6'(i + 8 * r),
                          {16'h0, 32'($random(seed))}, 28'(64 * (i + 1))));
      end
      for (int i = 0; i < 4; i++) begin
        send_good_ack(2'(i), 6'(i + 8 * r), 1'b0);
      end
      wait_idle();
    end
    random_bp <= 1'b0;
    wait_idle();

    $display("checks done: %0d value errors, %0d assertion failures",
             errors, DUT.checks.fail_count);
    if (errors == 0 && DUT.checks.fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog sized from the command count
  initial begin
    #(N_CMDS * 50 * CLK_NS + 200 * CLK_NS);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

endmodule

//--- roce_stack_assert.sv
// RoCE stack checks
// Concurrent assertions bound into the top level: credit limit,
// stable outputs under back-pressure and quiet outputs after reset
`timescale 1ns/10ps
`include "rdma_config.svh"

module roce_stack_assert
  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;
(
  input logic                                         nclk,
  input logic                                         nresetn,
  input logic [$clog2(`RDMA_MAX_OUTSTANDING + 1)-1:0] outstanding,
  input logic                                         sq_req_ready,
  input logic                                         tx_hdr_valid,
  input logic                                         tx_hdr_ready,
  input rdma_tx_hdr_t                                 tx_hdr,
  input logic                                         mem_rd_req_valid,
  input logic                                         mem_rd_req_ready,
  input rdma_mem_req_t                                mem_rd_req,
  input logic                                         ack_valid,
  input logic                                         rx_ack_ready,
  input logic                                         crc_drop_count_valid,
  input logic                                         psn_drop_count_valid
);

  int fail_count = 0;

  credit_limit: assert property (@(posedge nclk) disable iff (!nresetn)
    outstanding <= `RDMA_MAX_OUTSTANDING)
    else begin
      $error("outstanding count above the credit limit");
      fail_count++;
    end

  hdr_hold: assert property (@(posedge nclk) disable iff (!nresetn)
    (tx_hdr_valid && !tx_hdr_ready) |=> (tx_hdr_valid && $stable(tx_hdr)))
    else begin
      $error("tx_hdr changed or dropped while stalled");
      fail_count++;
    end

  mem_hold: assert property (@(posedge nclk) disable iff (!nresetn)
    (mem_rd_req_valid && !mem_rd_req_ready) |=> (mem_rd_req_valid && $stable(mem_rd_req)))
    else begin
      $error("mem_rd_req changed or dropped while stalled");
      fail_count++;
    end

  // Every valid and ready output low right after a reset cycle
  reset_quiet: assert property (@(posedge nclk)
    !nresetn |=> !(tx_hdr_valid || mem_rd_req_valid || ack_valid || sq_req_ready ||
                   rx_ack_ready || crc_drop_count_valid || psn_drop_count_valid))
    else begin
      $error("output active after reset");
      fail_count++;
    end

endmodule

//--- roce_stack.sv
// RoCE transport top level
// Send queue with a credit gate that caps outstanding work requests,
// buffered into the transmit engine. Received acknowledgements are
// buffered into the ACK receiver, whose notices return credit.
`timescale 1ns/10ps
`include "rdma_config.svh"

module roce_stack
  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;
(
  input  logic                     nclk,
  input  logic                     nresetn,
  input  logic [`RDMA_IP_BITS-1:0] local_ip_address,

  // User send queue
  input  logic                     sq_req_valid,
  output logic                     sq_req_ready,
  input  rdma_sq_req_t             sq_req,

  // Network transmit headers
  output logic                     tx_hdr_valid,
  input  logic                     tx_hdr_ready,
  output rdma_tx_hdr_t             tx_hdr,

  // Memory read commands
  output logic                     mem_rd_req_valid,
  input  logic                     mem_rd_req_ready,
  output rdma_mem_req_t            mem_rd_req,

  // Network receive acknowledgements
  input  logic                     rx_ack_valid,
  output logic                     rx_ack_ready,
  input  rdma_ack_pkt_t            rx_ack,

  // User acknowledgement notices
  output logic                     ack_valid,
  output rdma_ack_t                ack,

  output logic                     crc_drop_count_valid,
  output logic [31:0]              crc_drop_count,
  output logic                     psn_drop_count_valid,
  output logic [31:0]              psn_drop_count
);

  localparam int CREDIT_BITS = $clog2(`RDMA_MAX_OUTSTANDING + 1);

  logic [CREDIT_BITS-1:0] outstanding, outstanding_n;
  logic                   credit_ok;
  logic                   sq_accept;
  logic                   sq_fifo_in_valid, sq_fifo_in_ready;
  logic                   sq_valid, sq_ready;
  rdma_sq_req_t           sq_data;
  logic                   ack_pkt_valid, ack_pkt_ready;
  rdma_ack_pkt_t          ack_pkt;

  // Credit gate
  assign credit_ok        = (outstanding < CREDIT_BITS'(`RDMA_MAX_OUTSTANDING));
  assign sq_req_ready     = sq_fifo_in_ready & credit_ok;
  assign sq_fifo_in_valid = sq_req_valid & credit_ok;
  assign sq_accept        = sq_req_valid & sq_req_ready;

  always_comb begin
    outstanding_n = outstanding;
    // Every notice returns credit, NAK or not; a stray ack cannot underflow
    if (ack_valid && outstanding != '0) outstanding_n = outstanding_n - 1'b1;
    if (sq_accept) outstanding_n = outstanding_n + 1'b1;
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) outstanding <= '0;
    else outstanding <= outstanding_n;
  end

  meta_fifo #(.T(rdma_sq_req_t)) sq_fifo (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .in_valid  (sq_fifo_in_valid),
    .in_ready  (sq_fifo_in_ready),
    .in_data   (sq_req),
    .out_valid (sq_valid),
    .out_ready (sq_ready),
    .out_data  (sq_data)
  );

  rdma_tx_engine tx_engine (
    .nclk             (nclk),
    .nresetn          (nresetn),
    .local_ip_address (local_ip_address),
    .req_valid        (sq_valid),
    .req_ready        (sq_ready),
    .req              (sq_data),
    .tx_hdr_valid     (tx_hdr_valid),
    .tx_hdr_ready     (tx_hdr_ready),
    .tx_hdr           (tx_hdr),
    .mem_rd_req_valid (mem_rd_req_valid),
    .mem_rd_req_ready (mem_rd_req_ready),
    .mem_rd_req       (mem_rd_req)
  );

  meta_fifo #(.T(rdma_ack_pkt_t)) ack_fifo (
    .nclk      (nclk),
    .nresetn   (nresetn),
    .in_valid  (rx_ack_valid),
    .in_ready  (rx_ack_ready),
    .in_data   (rx_ack),
    .out_valid (ack_pkt_valid),
    .out_ready (ack_pkt_ready),
    .out_data  (ack_pkt)
  );

  rdma_ack_rx ack_rx (
    .nclk                 (nclk),
    .nresetn              (nresetn),
    .pkt_valid            (ack_pkt_valid),
    .pkt_ready            (ack_pkt_ready),
    .pkt                  (ack_pkt),
    .ack_valid            (ack_valid),
    .ack                  (ack),
    .crc_drop_count_valid (crc_drop_count_valid),
    .crc_drop_count       (crc_drop_count),
    .psn_drop_count_valid (psn_drop_count_valid),
    .psn_drop_count       (psn_drop_count)
  );

endmodule

//--- rdma_ack_rx.sv
// RDMA acknowledgement receiver
// Checks each incoming ACK/NAK against the expected psn of its queue
// pair. Bad CRC and out-of-sequence packets are dropped and counted;
// good ones raise a one-cycle notice and advance the expected psn.
`timescale 1ns/10ps
`include "rdma_config.svh"

module rdma_ack_rx
  import rdma_pkt_pkg::*;
(
  input  logic          nclk,
  input  logic          nresetn,

  // Received acknowledgements
  input  logic          pkt_valid,
  output logic          pkt_ready,
  input  rdma_ack_pkt_t pkt,

  // Notice to the user, always accepted
  output logic          ack_valid,
  output rdma_ack_t     ack,

  // Drop statistics
  output logic          crc_drop_count_valid,
  output logic [31:0]   crc_drop_count,
  output logic          psn_drop_count_valid,
  output logic [31:0]   psn_drop_count
);

  logic                      take;
  logic                      crc_bad;
  logic                      psn_bad;
  logic [`RDMA_PSN_BITS-1:0] exp_psn [`RDMA_N_QP];

  // The verdict never stalls so every packet is taken on arrival
  assign pkt_ready = 1'b1;
  assign take      = pkt_valid & pkt_ready;
  assign crc_bad   = ~pkt.crc_ok;
  assign psn_bad   = (pkt.psn != exp_psn[pkt.qpn]);

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      ack_valid            <= 1'b0;
      crc_drop_count_valid <= 1'b0;
      crc_drop_count       <= '0;
      psn_drop_count_valid <= 1'b0;
      psn_drop_count       <= '0;
      for (int i = 0; i < `RDMA_N_QP; i++) begin
        exp_psn[i] <= '0;
      end
    end else begin
      // Single-cycle pulses by default
      ack_valid            <= 1'b0;
      crc_drop_count_valid <= 1'b0;
      psn_drop_count_valid <= 1'b0;
      if (take) begin
        if (crc_bad) begin
          crc_drop_count       <= crc_drop_count + 1'b1;
          crc_drop_count_valid <= 1'b1;
        end else if (psn_bad) begin
          psn_drop_count       <= psn_drop_count + 1'b1;
          psn_drop_count_valid <= 1'b1;
        end else begin
          // NAKs are in sequence too and move the window
          ack_valid        <= 1'b1;
          exp_psn[pkt.qpn] <= exp_psn[pkt.qpn] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge nclk) begin
    if (take) begin
      ack.qpn      <= pkt.qpn;
      ack.pid      <= pkt.pid;
      ack.is_nak   <= pkt.is_nak;
      ack.syndrome <= pkt.syndrome;
      ack.msn      <= pkt.psn;
    end
  end

endmodule

//--- rdma_tx_engine.sv
// RDMA transmit engine
// Takes one work request at a time and turns it into a header
// descriptor stamped with the next psn of its queue pair and the
// local IP address. A WRITE also issues a memory read command for
// its payload; a READ issues only the header.
`timescale 1ns/10ps
`include "rdma_config.svh"

module rdma_tx_engine
  import rdma_cmd_pkg::*;
  import rdma_pkt_pkg::*;
(
  input  logic                     nclk,
  input  logic                     nresetn,
  input  logic [`RDMA_IP_BITS-1:0] local_ip_address,

  // Work requests
  input  logic                     req_valid,
  output logic                     req_ready,
  input  rdma_sq_req_t             req,

  // Header descriptors
  output logic                     tx_hdr_valid,
  input  logic                     tx_hdr_ready,
  output rdma_tx_hdr_t             tx_hdr,

  // Payload fetch
  output logic                     mem_rd_req_valid,
  input  logic                     mem_rd_req_ready,
  output rdma_mem_req_t            mem_rd_req
);

  logic                      take;
  logic                      is_write;
  logic [`RDMA_PSN_BITS-1:0] next_psn [`RDMA_N_QP];

  // One request in flight, both outputs must drain first
  assign req_ready = ~tx_hdr_valid & ~mem_rd_req_valid;
  assign take      = req_valid & req_ready;
  assign is_write  = (req.op == RDMA_WRITE);

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      tx_hdr_valid     <= 1'b0;
      mem_rd_req_valid <= 1'b0;
      for (int i = 0; i < `RDMA_N_QP; i++) begin
        next_psn[i] <= '0;
      end
    end else begin
      if (take) begin
        tx_hdr_valid            <= 1'b1;
        mem_rd_req_valid        <= is_write;
        next_psn[req.qpn]       <= next_psn[req.qpn] + 1'b1;
      end else begin
        // Each output retires on its own handshake
        if (tx_hdr_ready) tx_hdr_valid <= 1'b0;
        if (mem_rd_req_ready) mem_rd_req_valid <= 1'b0;
      end
    end
  end

  // Header fields
  always_ff @(posedge nclk) begin
    if (take) begin
      tx_hdr.op     <= req.op;
      tx_hdr.qpn    <= req.qpn;
      tx_hdr.psn    <= next_psn[req.qpn];
      tx_hdr.src_ip <= local_ip_address;
      tx_hdr.pid    <= req.pid;
      tx_hdr.len    <= req.len;
    end
  end

  // Memory command fields, only meaningful for a WRITE
  always_ff @(posedge nclk) begin
    if (take && is_write) begin
      mem_rd_req.vaddr <= req.vaddr;
      mem_rd_req.len   <= req.len;
      mem_rd_req.pid   <= req.pid;
      mem_rd_req.qpn   <= req.qpn;
    end
  end

endmodule

//--- meta_fifo.sv
// Metadata FIFO
// Circular buffer with a registered output stage for valid/ready
// streams; the payload type is a parameter
`timescale 1ns/10ps
`include "rdma_config.svh"

module meta_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = `RDMA_FIFO_DEPTH
) (
  input  logic nclk,
  input  logic nresetn,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
  logic [PTR_BITS:0]   count, count_n;
  logic                push, pop;

  assign push = in_valid & in_ready;
  // Refill the output stage when it is empty or being drained
  assign pop  = (count != '0) & (~out_valid | out_ready);

  always_comb begin
    count_n = count;
    if (push && !pop) count_n = count + 1'b1;
    else if (!push && pop) count_n = count - 1'b1;
  end

  always_ff @(posedge nclk) begin
    if (!nresetn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_ready  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count    <= count_n;
      // Ready is registered so it stays low through reset
      in_ready <= (count_n < (PTR_BITS + 1)'(DEPTH));
      if (pop) out_valid <= 1'b1;
      else if (out_ready) out_valid <= 1'b0;
    end
  end

  always_ff @(posedge nclk) begin
    if (push) mem[wr_ptr] <= in_data;
    if (pop) out_data <= mem[rd_ptr];
  end

endmodule

//--- rdma_pkt_pkg.sv
// RDMA packet types
// Transmit header descriptors, received acknowledgement packets
// and the acknowledgement notice handed back to the user
package rdma_pkt_pkg;

`include "rdma_config.svh"

  import rdma_cmd_pkg::*;

  // Header descriptor for the network side
  typedef struct packed {
    rdma_op_e                   op;
    logic [`RDMA_QPN_BITS-1:0]   qpn;
    logic [`RDMA_PSN_BITS-1:0]   psn;
    logic [`RDMA_IP_BITS-1:0]    src_ip;
    logic [`RDMA_PID_BITS-1:0]   pid;
    logic [`RDMA_LEN_BITS-1:0]   len;
  } rdma_tx_hdr_t;

  // Parsed ACK/NAK, CRC already checked upstream
  typedef struct packed {
    logic [`RDMA_QPN_BITS-1:0]   qpn;
    logic [`RDMA_PSN_BITS-1:0]   psn;
    logic [`RDMA_PID_BITS-1:0]   pid;
    logic                        is_nak;
    logic [`RDMA_SNDRM_BITS-1:0] syndrome;
    logic                        crc_ok;
  } rdma_ack_pkt_t;

  // Notice to the user, msn is the acknowledged psn
  typedef struct packed {
    logic [`RDMA_QPN_BITS-1:0]   qpn;
    logic [`RDMA_PID_BITS-1:0]   pid;
    logic                        is_nak;
    logic [`RDMA_SNDRM_BITS-1:0] syndrome;
    logic [`RDMA_PSN_BITS-1:0]   msn;
  } rdma_ack_t;

endpackage

//--- rdma_cmd_pkg.sv
// RDMA command types
// User work requests on the send queue and the memory commands
// that fetch WRITE payloads
package rdma_cmd_pkg;

`include "rdma_config.svh"

  // RC opcodes for the two supported verbs
  typedef enum logic [`RDMA_OP_BITS-1:0] {
    RDMA_WRITE = 5'h0a,
    RDMA_READ  = 5'h0c
  } rdma_op_e;

  // Work request from the user
  typedef struct packed {
    rdma_op_e                   op;
    logic [`RDMA_QPN_BITS-1:0]   qpn;
    logic [`RDMA_PID_BITS-1:0]   pid;
    logic [`RDMA_VADDR_BITS-1:0] vaddr;
    logic [`RDMA_LEN_BITS-1:0]   len;
  } rdma_sq_req_t;

  // Read command towards host memory
  typedef struct packed {
    logic [`RDMA_VADDR_BITS-1:0] vaddr;
    logic [`RDMA_LEN_BITS-1:0]   len;
    logic [`RDMA_PID_BITS-1:0]   pid;
    logic [`RDMA_QPN_BITS-1:0]   qpn;
  } rdma_mem_req_t;

endpackage

//--- rdma_config.svh
// RoCE transport configuration
// Sizing of the credit gate, queue pair tables and FIFOs, plus the
// field widths shared by the command and packet types
`ifndef RDMA_CONFIG_SVH
`define RDMA_CONFIG_SVH

// Work requests accepted and not yet acknowledged
`define RDMA_MAX_OUTSTANDING 4

// Queue pairs
`define RDMA_N_QP 4
`define RDMA_QPN_BITS 2

`define RDMA_FIFO_DEPTH 4

// Field widths
`define RDMA_OP_BITS 5
`define RDMA_PSN_BITS 24
`define RDMA_VADDR_BITS 48
`define RDMA_LEN_BITS 28
`define RDMA_PID_BITS 6
`define RDMA_SNDRM_BITS 8
`define RDMA_IP_BITS 32

`endif
